//--- hw/tcdm_params.svh
/*
 * TCDM sizing
 * Bank count, bank depth and bus widths of the shared data memory
 */

`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// Number of word-interleaved banks
`define TCDM_NB_BANKS 4

// Words per bank
`define TCDM_BANK_WORDS 64

// Data width in bits, byte enables are this divided by 8
`define TCDM_DATA_WIDTH 32

// Byte address width
`define TCDM_ADDR_WIDTH 32

// Transaction id width
`define TCDM_ID_WIDTH 4

`endif

//--- hw/tcdm_pkg.sv
/*
 * TCDM shared types
 * Request opcode and per-bank arbitration priority, shared by the
 * port decoders, the bank arbiter and the checker
 */

package tcdm_pkg;

  // Request opcode, one bit
  // Replaces the active-low write enable of the older bank interface
  typedef enum logic {
    TCDM_OP_READ  = 1'b0,  // Read one word, data returned next cycle
    TCDM_OP_WRITE = 1'b1   // Write enabled bytes, id echoed next cycle
  } tcdm_op_e;

  // Port that wins the next conflict on a bank
  // Flips to the losing port after every conflict
  typedef enum logic {
    PRIO_CORE = 1'b0,      // Core port first, also the reset state
    PRIO_DMA  = 1'b1       // DMA port first
  } tcdm_prio_e;

endpackage : tcdm_pkg

//--- hw/tcdm_port_decoder.sv
/*
 * TCDM port decoder
 * Splits one initiator's byte address into an interleaved bank select
 * and a bank row, the other request fields pass through alongside
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tcdm_port_decoder
  import tcdm_pkg::*;
(
  // Request from the initiator
  input  logic                                 req_i,
  input  logic [`TCDM_ADDR_WIDTH-1:0]          addr_i,
  input  tcdm_op_e                             op_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]          wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0]        be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]            id_i,

  // Decoded request towards the arbiter
  output logic                                 req_o,
  output logic [$clog2(`TCDM_NB_BANKS)-1:0]    bank_o,
  output logic [$clog2(`TCDM_BANK_WORDS)-1:0]  row_o,
  output tcdm_op_e                             op_o,
  output logic [`TCDM_DATA_WIDTH-1:0]          wdata_o,
  output logic [`TCDM_DATA_WIDTH/8-1:0]        be_o,
  output logic [`TCDM_ID_WIDTH-1:0]            id_o
);

  localparam int unsigned bank_bits = $clog2(`TCDM_NB_BANKS);
  localparam int unsigned row_bits  = $clog2(`TCDM_BANK_WORDS);

  logic [row_bits-1:0] row;     // Row field, upper address bits alias
  logic                row_ok;  // Row lies inside the bank

  // Byte offset in bits [1:0] is dropped, consecutive words hit consecutive banks
  assign bank_o = addr_i[2 +: bank_bits];
  assign row    = addr_i[2 + bank_bits +: row_bits];

  // Only false for a bank depth that is not a power of two
  assign row_ok = (32'(row) < `TCDM_BANK_WORDS);

  assign req_o = req_i & row_ok;  // Out-of-range rows never reach a bank
  assign row_o = row;

  // Payload fields travel unchanged
  assign op_o    = op_i;
  assign wdata_o = wdata_i;
  assign be_o    = be_i;
  assign id_o    = id_i;

endmodule : tcdm_port_decoder

//--- hw/tcdm_bank_arbiter.sv
/*
 * TCDM bank arbiter
 * Per-bank round-robin between the core and DMA ports, combinational
 * grants, and routing of bank responses back through an owner register
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tcdm_bank_arbiter
  import tcdm_pkg::*;
(
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,

  // Decoded core request
  input  logic                                                      core_req_i,
  input  logic [$clog2(`TCDM_NB_BANKS)-1:0]                         core_bank_i,
  input  logic [$clog2(`TCDM_BANK_WORDS)-1:0]                       core_row_i,
  input  tcdm_op_e                                                  core_op_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]                               core_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0]                             core_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]                                 core_id_i,

  // Decoded DMA request
  input  logic                                                      dma_req_i,
  input  logic [$clog2(`TCDM_NB_BANKS)-1:0]                         dma_bank_i,
  input  logic [$clog2(`TCDM_BANK_WORDS)-1:0]                       dma_row_i,
  input  tcdm_op_e                                                  dma_op_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]                               dma_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0]                             dma_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]                                 dma_id_i,

  // Port side
  output logic                                                      core_gnt_o,
  output logic                                                      dma_gnt_o,
  output logic                                                      core_r_valid_o,
  output logic                                                      dma_r_valid_o,
  output logic [`TCDM_DATA_WIDTH-1:0]                               core_r_data_o,
  output logic [`TCDM_DATA_WIDTH-1:0]                               dma_r_data_o,
  output logic [`TCDM_ID_WIDTH-1:0]                                 core_r_id_o,
  output logic [`TCDM_ID_WIDTH-1:0]                                 dma_r_id_o,

  // Bank side, packed over banks
  output logic [`TCDM_NB_BANKS-1:0]                                 bank_req_o,
  output logic [`TCDM_NB_BANKS-1:0]                                 bank_we_o,
  output logic [`TCDM_NB_BANKS-1:0][$clog2(`TCDM_BANK_WORDS)-1:0]   bank_row_o,
  output logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH-1:0]           bank_wdata_o,
  output logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH/8-1:0]         bank_be_o,
  output logic [`TCDM_NB_BANKS-1:0][`TCDM_ID_WIDTH-1:0]             bank_id_o,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH-1:0]           bank_rdata_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_ID_WIDTH-1:0]             bank_rid_i
);

  localparam int unsigned nb_banks  = `TCDM_NB_BANKS;
  localparam int unsigned bank_bits = $clog2(`TCDM_NB_BANKS);

  logic [nb_banks-1:0] core_hit, dma_hit;     // Port addresses this bank
  logic [nb_banks-1:0] core_win, dma_win;     // Port owns this bank now
  tcdm_prio_e          prio_q [nb_banks];     // Conflict winner per bank
  logic [nb_banks-1:0] resp_due_q;            // Bank answers this cycle
  logic [nb_banks-1:0] resp_dma_q;            // Answer belongs to DMA

  for (genvar b = 0; b < nb_banks; b++) begin : gen_bank
    assign core_hit[b] = core_req_i && (core_bank_i == bank_bits'(b));
    assign dma_hit[b]  = dma_req_i && (dma_bank_i == bank_bits'(b));

    // Core takes the bank when alone or when it holds priority
    assign core_win[b] = core_hit[b] && (!dma_hit[b] || prio_q[b] == PRIO_CORE);
    assign dma_win[b]  = dma_hit[b] && !core_win[b];

    // Bank inputs follow the winner, core fields when idle
    assign bank_req_o[b]   = core_win[b] | dma_win[b];
    assign bank_we_o[b]    = dma_win[b] ? (dma_op_i == TCDM_OP_WRITE)
                                        : (core_op_i == TCDM_OP_WRITE);
    assign bank_row_o[b]   = dma_win[b] ? dma_row_i   : core_row_i;
    assign bank_wdata_o[b] = dma_win[b] ? dma_wdata_i : core_wdata_i;
    assign bank_be_o[b]    = dma_win[b] ? dma_be_i    : core_be_i;
    assign bank_id_o[b]    = dma_win[b] ? dma_id_i    : core_id_i;
  end

  // Each port targets one bank per cycle, so one win at most
  assign core_gnt_o = |core_win;
  assign dma_gnt_o  = |dma_win;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < nb_banks; b++) begin
        prio_q[b] <= PRIO_CORE;
      end
      resp_due_q <= '0;
      resp_dma_q <= '0;
    end else begin
      for (int b = 0; b < nb_banks; b++) begin
        if (core_hit[b] && dma_hit[b]) begin
          prio_q[b] <= core_win[b] ? PRIO_DMA : PRIO_CORE;  // Loser goes first next time
        end
      end
      resp_due_q <= core_win | dma_win;  // Reads and writes both answer
      resp_dma_q <= dma_win;
    end
  end

  // Steer last cycle's bank outputs to their owners
  always_comb begin
    core_r_valid_o = 1'b0;
    core_r_data_o  = '0;
    core_r_id_o    = '0;
    dma_r_valid_o  = 1'b0;
    dma_r_data_o   = '0;
    dma_r_id_o     = '0;
    for (int b = 0; b < nb_banks; b++) begin
      if (resp_due_q[b] && !resp_dma_q[b]) begin
        core_r_valid_o = 1'b1;
        core_r_data_o  = bank_rdata_i[b];
        core_r_id_o    = bank_rid_i[b];
      end
      if (resp_due_q[b] && resp_dma_q[b]) begin
        dma_r_valid_o = 1'b1;
        dma_r_data_o  = bank_rdata_i[b];
        dma_r_id_o    = bank_rid_i[b];
      end
    end
  end

endmodule : tcdm_bank_arbiter

//--- hw/tcdm_banks_wrap.sv
/*
 * TCDM banks
 * One single-port word memory per bank with byte-enable writes,
 * one-cycle read latency and a registered echo of the request id
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tcdm_banks_wrap (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,

  // Per-bank request, packed over banks
  input  logic [`TCDM_NB_BANKS-1:0]                                req_i,
  input  logic [`TCDM_NB_BANKS-1:0]                                we_i,
  input  logic [`TCDM_NB_BANKS-1:0][$clog2(`TCDM_BANK_WORDS)-1:0]  row_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH-1:0]          wdata_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH/8-1:0]        be_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_ID_WIDTH-1:0]            id_i,

  // Per-bank response, one cycle after the request
  output logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_WIDTH-1:0]          rdata_o,
  output logic [`TCDM_NB_BANKS-1:0][`TCDM_ID_WIDTH-1:0]            rid_o
);

  localparam int unsigned nb_banks   = `TCDM_NB_BANKS;
  localparam int unsigned bank_words = `TCDM_BANK_WORDS;
  localparam int unsigned data_width = `TCDM_DATA_WIDTH;
  localparam int unsigned be_width   = `TCDM_DATA_WIDTH / 8;
  localparam int unsigned id_width   = `TCDM_ID_WIDTH;

  for (genvar b = 0; b < nb_banks; b++) begin : gen_bank
    logic [data_width-1:0] mem [bank_words];  // Undefined until written
    logic [data_width-1:0] rdata_q;
    logic [id_width-1:0]   rid_q;

    // Memory port, write enabled bytes or read the whole word
    always_ff @(posedge clk_i) begin
      if (req_i[b]) begin
        if (we_i[b]) begin
          for (int j = 0; j < be_width; j++) begin
            if (be_i[b][j]) begin
              mem[row_i[b]][8*j +: 8] <= wdata_i[b][8*j +: 8];
            end
          end
        end else begin
          rdata_q <= mem[row_i[b]];  // Holds last read across writes
        end
      end
    end

    // Id echo for the response
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rid_q <= '0;
      end else if (req_i[b]) begin
        rid_q <= id_i[b];
      end
    end

    assign rdata_o[b] = rdata_q;
    assign rid_o[b]   = rid_q;
  end

endmodule : tcdm_banks_wrap

//--- hw/tcdm_subsystem.sv
/*
 * TCDM subsystem
 * Two-port shared data memory, core and DMA decoders feed a per-bank
 * arbiter in front of the word-interleaved banks
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tcdm_subsystem
  import tcdm_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Core port
  input  logic                           core_req_i,
  input  tcdm_op_e                       core_op_i,
  input  logic [`TCDM_ADDR_WIDTH-1:0]    core_addr_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]    core_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0]  core_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]      core_id_i,
  output logic                           core_gnt_o,
  output logic                           core_r_valid_o,
  output logic [`TCDM_DATA_WIDTH-1:0]    core_r_data_o,
  output logic [`TCDM_ID_WIDTH-1:0]      core_r_id_o,

  // DMA port
  input  logic                           dma_req_i,
  input  tcdm_op_e                       dma_op_i,
  input  logic [`TCDM_ADDR_WIDTH-1:0]    dma_addr_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]    dma_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0]  dma_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]      dma_id_i,
  output logic                           dma_gnt_o,
  output logic                           dma_r_valid_o,
  output logic [`TCDM_DATA_WIDTH-1:0]    dma_r_data_o,
  output logic [`TCDM_ID_WIDTH-1:0]      dma_r_id_o
);

  localparam int unsigned nb_banks   = `TCDM_NB_BANKS;
  localparam int unsigned bank_bits  = $clog2(`TCDM_NB_BANKS);
  localparam int unsigned row_bits   = $clog2(`TCDM_BANK_WORDS);
  localparam int unsigned data_width = `TCDM_DATA_WIDTH;
  localparam int unsigned be_width   = `TCDM_DATA_WIDTH / 8;
  localparam int unsigned id_width   = `TCDM_ID_WIDTH;

  // Decoded core request
  logic                  core_dec_req;
  logic [bank_bits-1:0]  core_dec_bank;
  logic [row_bits-1:0]   core_dec_row;
  tcdm_op_e              core_dec_op;
  logic [data_width-1:0] core_dec_wdata;
  logic [be_width-1:0]   core_dec_be;
  logic [id_width-1:0]   core_dec_id;

  // Decoded DMA request
  logic                  dma_dec_req;
  logic [bank_bits-1:0]  dma_dec_bank;
  logic [row_bits-1:0]   dma_dec_row;
  tcdm_op_e              dma_dec_op;
  logic [data_width-1:0] dma_dec_wdata;
  logic [be_width-1:0]   dma_dec_be;
  logic [id_width-1:0]   dma_dec_id;

  // Arbiter to banks and back
  logic [nb_banks-1:0]                 bank_req, bank_we;
  logic [nb_banks-1:0][row_bits-1:0]   bank_row;
  logic [nb_banks-1:0][data_width-1:0] bank_wdata, bank_rdata;
  logic [nb_banks-1:0][be_width-1:0]   bank_be;
  logic [nb_banks-1:0][id_width-1:0]   bank_id, bank_rid;

  tcdm_port_decoder u_core_dec (
    .req_i   (core_req_i),
    .addr_i  (core_addr_i),
    .op_i    (core_op_i),
    .wdata_i (core_wdata_i),
    .be_i    (core_be_i),
    .id_i    (core_id_i),
    .req_o   (core_dec_req),
    .bank_o  (core_dec_bank),
    .row_o   (core_dec_row),
    .op_o    (core_dec_op),
    .wdata_o (core_dec_wdata),
    .be_o    (core_dec_be),
    .id_o    (core_dec_id)
  );

  tcdm_port_decoder u_dma_dec (
    .req_i   (dma_req_i),
    .addr_i  (dma_addr_i),
    .op_i    (dma_op_i),
    .wdata_i (dma_wdata_i),
    .be_i    (dma_be_i),
    .id_i    (dma_id_i),
    .req_o   (dma_dec_req),
    .bank_o  (dma_dec_bank),
    .row_o   (dma_dec_row),
    .op_o    (dma_dec_op),
    .wdata_o (dma_dec_wdata),
    .be_o    (dma_dec_be),
    .id_o    (dma_dec_id)
  );

  tcdm_bank_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_req_i     (core_dec_req),
    .core_bank_i    (core_dec_bank),
    .core_row_i     (core_dec_row),
    .core_op_i      (core_dec_op),
    .core_wdata_i   (core_dec_wdata),
    .core_be_i      (core_dec_be),
    .core_id_i      (core_dec_id),
    .dma_req_i      (dma_dec_req),
    .dma_bank_i     (dma_dec_bank),
    .dma_row_i      (dma_dec_row),
    .dma_op_i       (dma_dec_op),
    .dma_wdata_i    (dma_dec_wdata),
    .dma_be_i       (dma_dec_be),
    .dma_id_i       (dma_dec_id),
    .core_gnt_o     (core_gnt_o),
    .dma_gnt_o      (dma_gnt_o),
    .core_r_valid_o (core_r_valid_o),
    .dma_r_valid_o  (dma_r_valid_o),
    .core_r_data_o  (core_r_data_o),
    .dma_r_data_o   (dma_r_data_o),
    .core_r_id_o    (core_r_id_o),
    .dma_r_id_o     (dma_r_id_o),
    .bank_req_o     (bank_req),
    .bank_we_o      (bank_we),
    .bank_row_o     (bank_row),
    .bank_wdata_o   (bank_wdata),
    .bank_be_o      (bank_be),
    .bank_id_o      (bank_id),
    .bank_rdata_i   (bank_rdata),
    .bank_rid_i     (bank_rid)
  );

  tcdm_banks_wrap u_banks (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .row_i   (bank_row),
    .wdata_i (bank_wdata),
    .be_i    (bank_be),
    .id_i    (bank_id),
    .rdata_o (bank_rdata),
    .rid_o   (bank_rid)
  );

endmodule : tcdm_subsystem

//--- testbench/tcdm_checker.sv
/*
 * TCDM checker
 * Watches both ports of the subsystem, mirrors the per-bank round-robin
 * state and a byte-wise memory, and compares grants, ids and read data
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tcdm_checker
  import tcdm_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          core_req_i,
  input  tcdm_op_e                      core_op_i,
  input  logic [`TCDM_ADDR_WIDTH-1:0]   core_addr_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]   core_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0] core_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]     core_id_i,
  input  logic                          core_gnt_i,
  input  logic                          core_r_valid_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]   core_r_data_i,
  input  logic [`TCDM_ID_WIDTH-1:0]     core_r_id_i,
  input  logic                          dma_req_i,
  input  tcdm_op_e                      dma_op_i,
  input  logic [`TCDM_ADDR_WIDTH-1:0]   dma_addr_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]   dma_wdata_i,
  input  logic [`TCDM_DATA_WIDTH/8-1:0] dma_be_i,
  input  logic [`TCDM_ID_WIDTH-1:0]     dma_id_i,
  input  logic                          dma_gnt_i,
  input  logic                          dma_r_valid_i,
  input  logic [`TCDM_DATA_WIDTH-1:0]   dma_r_data_i,
  input  logic [`TCDM_ID_WIDTH-1:0]     dma_r_id_i,
  input  int                            test_i,      // Test number of the applied row
  input  logic                          all_sent_i,  // Every row applied and drained
  output logic                          idle_o,      // No response outstanding
  output logic                          done_o,      // Closing line printed
  output int                            errors_o
);

  localparam int unsigned nb_banks = `TCDM_NB_BANKS;
  localparam int unsigned nb_words = `TCDM_NB_BANKS * `TCDM_BANK_WORDS;
  localparam int unsigned be_width = `TCDM_DATA_WIDTH / 8;

  // One expected response
  typedef struct packed {
    logic [31:0]                 due;   // Rising edge that must see r_valid
    logic [be_width-1:0]         mask;  // Read bytes with a known value
    logic [`TCDM_DATA_WIDTH-1:0] data;
    logic [`TCDM_ID_WIDTH-1:0]   id;
  } resp_t;

  tcdm_prio_e prio_model [nb_banks];         // Conflict winner per bank
  logic [7:0] mem_byte   [nb_words][be_width];
  bit         mem_known  [nb_words][be_width];  // Byte written at least once
  resp_t      core_q [$], dma_q [$];
  int         cycle, cur_test, test_checks, test_errors;
  int         checks, tests_run, tests_failed;

  initial begin
    idle_o   = 1'b1;
    done_o   = 1'b0;
    errors_o = 0;
  end

  // Word index with the bank in the low bits and the row above them
  function automatic int word_of(logic [`TCDM_ADDR_WIDTH-1:0] addr);
    return int'((addr >> 2) % nb_words);
  endfunction

  task automatic flag_error(input bit wrong_value, input string msg);
    if (wrong_value) begin
      $display("FAIL @ %0d ns: %s", $time, msg);
    end else begin
      $display("Error at %0d ns: %s", $time, msg);
    end
    test_errors++;
    errors_o++;
  endtask

  task automatic check_response(input bit is_dma, input logic valid,
                                input logic [`TCDM_DATA_WIDTH-1:0] data,
                                input logic [`TCDM_ID_WIDTH-1:0] id);
    resp_t                       exp;
    logic [`TCDM_DATA_WIDTH-1:0] bits;
    string                       name;
    bit                          have;
    name = is_dma ? "dma" : "core";
    have = is_dma ? (dma_q.size() > 0) : (core_q.size() > 0);
    exp  = '0;
    if (have) begin
      exp = is_dma ? dma_q[0] : core_q[0];
    end
    if (valid && !have) begin
      flag_error(1'b0, $sformatf("%s response pulse arrived with no request outstanding", name));
    end else if (have && (valid || exp.due <= cycle)) begin
      if (is_dma) begin
        dma_q.delete(0);
      end else begin
        core_q.delete(0);
      end
      test_checks++;
      checks++;
      for (int j = 0; j < be_width; j++) begin
        bits[8*j +: 8] = {8{exp.mask[j]}};  // Unknown bytes are not compared
      end
      if (!valid) begin
        flag_error(1'b0, $sformatf("%s response for id %h never arrived", name, exp.id));
      end else if (id !== exp.id) begin
        flag_error(1'b1, $sformatf("%s response id %h, expected %h", name, id, exp.id));
      end else if ((data & bits) !== (exp.data & bits)) begin
        flag_error(1'b1, $sformatf("%s read data %h, expected %h under byte mask %h",
                                   name, data, exp.data, bits));
      end
    end
  endtask

  // Accepted request updates the memory model before queuing the response
  task automatic accept(input bit is_dma, input tcdm_op_e op,
                        input logic [`TCDM_ADDR_WIDTH-1:0] addr,
                        input logic [`TCDM_DATA_WIDTH-1:0] wdata,
                        input logic [be_width-1:0] be,
                        input logic [`TCDM_ID_WIDTH-1:0] id);
    resp_t e;
    int    w;
    w     = word_of(addr);
    e     = '0;
    e.due = cycle + 1;  // Seen at the very next rising edge
    e.id  = id;
    for (int j = 0; j < be_width; j++) begin
      if (op == TCDM_OP_WRITE && be[j]) begin
        mem_byte[w][j]  = wdata[8*j +: 8];
        mem_known[w][j] = 1'b1;
      end else if (op == TCDM_OP_READ) begin
        e.data[8*j +: 8] = mem_byte[w][j];
        e.mask[j]        = mem_known[w][j];
      end
    end
    if (is_dma) begin
      dma_q.push_back(e);
    end else begin
      core_q.push_back(e);
    end
  endtask

  task automatic check_grants();
    int   cb, db;
    logic exp_core, exp_dma;
    cb       = word_of(core_addr_i) % nb_banks;
    db       = word_of(dma_addr_i) % nb_banks;
    exp_core = core_req_i;
    exp_dma  = dma_req_i;
    if (core_req_i && dma_req_i && cb == db) begin
      if (prio_model[cb] == PRIO_CORE) begin
        exp_dma        = 1'b0;
        prio_model[cb] = PRIO_DMA;   // Loser goes first on the next conflict
      end else begin
        exp_core       = 1'b0;
        prio_model[cb] = PRIO_CORE;
      end
    end
    if (core_req_i || dma_req_i) begin
      test_checks++;
      checks++;
    end
    if (core_gnt_i !== exp_core) begin
      flag_error(1'b1, $sformatf("core grant %b, expected %b", core_gnt_i, exp_core));
    end
    if (dma_gnt_i !== exp_dma) begin
      flag_error(1'b1, $sformatf("dma grant %b, expected %b", dma_gnt_i, exp_dma));
    end
    if (core_req_i && core_gnt_i) begin
      accept(1'b0, core_op_i, core_addr_i, core_wdata_i, core_be_i, core_id_i);
    end
    if (dma_req_i && dma_gnt_i) begin
      accept(1'b1, dma_op_i, dma_addr_i, dma_wdata_i, dma_be_i, dma_id_i);
    end
  endtask

  task automatic close_test(input int next_test);
    if (cur_test != 0) begin
      tests_run++;
      if (test_errors == 0) begin
        $display("Test %0d done: %0d checks, no errors", cur_test, test_checks);
      end else begin
        tests_failed++;
        $display("Test %0d done: %0d errors in %0d checks", cur_test, test_errors, test_checks);
      end
    end
    cur_test    = next_test;
    test_checks = 0;
    test_errors = 0;
  endtask

  // Samples at the rising edge before any DUT register moves
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < nb_banks; b++) begin
        prio_model[b] = PRIO_CORE;
      end
      core_q.delete();
      dma_q.delete();
      cycle = 0;
    end else begin
      cycle++;
      check_response(1'b0, core_r_valid_i, core_r_data_i, core_r_id_i);
      check_response(1'b1, dma_r_valid_i, dma_r_data_i, dma_r_id_i);
      if (test_i != cur_test) begin
        close_test(test_i);
      end
      check_grants();
      if (all_sent_i && !done_o && core_q.size() == 0 && dma_q.size() == 0) begin
        close_test(0);
        $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors_o);
        done_o = 1'b1;
      end
      idle_o = (core_q.size() == 0) && (dma_q.size() == 0);
    end
  end

endmodule : tcdm_checker

//--- testbench/tb_tcdm_subsystem.sv
/*
 * TCDM subsystem testbench
 * Applies a table of core and DMA requests, one row per falling edge,
 * while the checker compares every grant and response
 */

`timescale 1ns/1ps
`include "tcdm_params.svh"

module tb_tcdm_subsystem;
  import tcdm_pkg::*;

  localparam int max_rows = 96;

  // One port's request fields
  typedef struct packed {
    logic                          req;
    tcdm_op_e                      op;
    logic [`TCDM_ADDR_WIDTH-1:0]   addr;
    logic [`TCDM_DATA_WIDTH-1:0]   wdata;
    logic [`TCDM_DATA_WIDTH/8-1:0] be;
    logic [`TCDM_ID_WIDTH-1:0]     id;
  } port_req_t;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  port_req_t                   core_drv, dma_drv;  // Driven on falling edges
  logic                        core_gnt, core_r_valid, dma_gnt, dma_r_valid;
  logic [`TCDM_DATA_WIDTH-1:0] core_r_data, dma_r_data;
  logic [`TCDM_ID_WIDTH-1:0]   core_r_id, dma_r_id;
  int                          test_num;
  logic                        all_sent;
  logic                        chk_idle, chk_done;
  int                          chk_errors;

  port_req_t                   core_tab [max_rows];
  port_req_t                   dma_tab  [max_rows];
  int                          test_tab [max_rows];
  int                          num_rows;
  logic [31:0]                 written_q [$];  // Addresses written so far
  int                          cycle_count;
  int                          cycle_limit = 1000;

  always #4 clk_i = ~clk_i;  // 8 ns period

  tcdm_subsystem u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_req_i     (core_drv.req),
    .core_op_i      (core_drv.op),
    .core_addr_i    (core_drv.addr),
    .core_wdata_i   (core_drv.wdata),
    .core_be_i      (core_drv.be),
    .core_id_i      (core_drv.id),
    .core_gnt_o     (core_gnt),
    .core_r_valid_o (core_r_valid),
    .core_r_data_o  (core_r_data),
    .core_r_id_o    (core_r_id),
    .dma_req_i      (dma_drv.req),
    .dma_op_i       (dma_drv.op),
    .dma_addr_i     (dma_drv.addr),
    .dma_wdata_i    (dma_drv.wdata),
    .dma_be_i       (dma_drv.be),
    .dma_id_i       (dma_drv.id),
    .dma_gnt_o      (dma_gnt),
    .dma_r_valid_o  (dma_r_valid),
    .dma_r_data_o   (dma_r_data),
    .dma_r_id_o     (dma_r_id)
  );

  tcdm_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_req_i     (core_drv.req),
    .core_op_i      (core_drv.op),
    .core_addr_i    (core_drv.addr),
    .core_wdata_i   (core_drv.wdata),
    .core_be_i      (core_drv.be),
    .core_id_i      (core_drv.id),
    .core_gnt_i     (core_gnt),
    .core_r_valid_i (core_r_valid),
    .core_r_data_i  (core_r_data),
    .core_r_id_i    (core_r_id),
    .dma_req_i      (dma_drv.req),
    .dma_op_i       (dma_drv.op),
    .dma_addr_i     (dma_drv.addr),
    .dma_wdata_i    (dma_drv.wdata),
    .dma_be_i       (dma_drv.be),
    .dma_id_i       (dma_drv.id),
    .dma_gnt_i      (dma_gnt),
    .dma_r_valid_i  (dma_r_valid),
    .dma_r_data_i   (dma_r_data),
    .dma_r_id_i     (dma_r_id),
    .test_i         (test_num),
    .all_sent_i     (all_sent),
    .idle_o         (chk_idle),
    .done_o         (chk_done),
    .errors_o       (chk_errors)
  );

  function automatic port_req_t no_req();
    return '0;
  endfunction

  function automatic port_req_t read_req(logic [31:0] addr, logic [3:0] id);
    return '{1'b1, TCDM_OP_READ, addr, '0, '1, id};
  endfunction

  function automatic port_req_t write_req(logic [31:0] addr, logic [31:0] data,
                                          logic [3:0] be, logic [3:0] id);
    return '{1'b1, TCDM_OP_WRITE, addr, data, be, id};
  endfunction

  // Busy about four rows in five, reads only hit words written before
  function automatic port_req_t random_req();
    logic [31:0] addr;
    addr = 32'($urandom_range(255)) << 2;
    if ($urandom_range(4) == 0) begin
      return no_req();
    end else if ($urandom_range(1) == 1) begin
      return write_req(addr, $urandom, 4'($urandom_range(15, 1)), 4'($urandom));
    end
    return read_req(written_q[$urandom_range(written_q.size() - 1)], 4'($urandom));
  endfunction

  task automatic add_row(input int test, input port_req_t core, input port_req_t dma);
    test_tab[num_rows] = test;
    core_tab[num_rows] = core;
    dma_tab[num_rows]  = dma;
    num_rows++;
    if (core.req && core.op == TCDM_OP_WRITE) begin
      written_q.push_back(core.addr);
    end
    if (dma.req && dma.op == TCDM_OP_WRITE) begin
      written_q.push_back(dma.addr);
    end
  endtask

  task automatic build_table();
    // Full words through every bank, then read back
    for (int i = 0; i < 8; i++) begin
      add_row(1, write_req(32'(i * 4), 32'hc0de_0000 + 32'(i) * 32'h0101, 4'hf, 4'(i)),
              no_req());
    end
    for (int i = 0; i < 8; i++) begin
      add_row(1, read_req(32'(i * 4), 4'(i + 8)), no_req());
    end
    // Partial writes merge, upper half of 0x100 stays unknown
    add_row(2, write_req(32'h04, 32'h5a5a_5a5a, 4'b0001, 4'h1), no_req());
    add_row(2, write_req(32'h04, 32'h1234_5678, 4'b0110, 4'h2), no_req());
    add_row(2, no_req(), write_req(32'h04, 32'hff00_0000, 4'b1000, 4'h3));
    add_row(2, write_req(32'h100, 32'hbeef_cafe, 4'b0011, 4'h4), no_req());
    add_row(2, read_req(32'h04, 4'h5), read_req(32'h100, 4'h6));
    // Different banks in the same cycle
    add_row(3, write_req(32'h20, 32'h0a0b_0c0d, 4'hf, 4'h1),
            write_req(32'h24, 32'h1a1b_1c1d, 4'hf, 4'h2));
    add_row(3, read_req(32'h24, 4'h3), read_req(32'h20, 4'h4));
    add_row(3, read_req(32'h08, 4'h5), read_req(32'h0c, 4'h6));
    // Conflicts on bank 0 alternate, bank 3 starts from core
    add_row(4, read_req(32'h00, 4'h1), read_req(32'h10, 4'h2));
    add_row(4, write_req(32'h40, 32'h4444_4444, 4'hf, 4'h3), read_req(32'h00, 4'h4));
    add_row(4, read_req(32'h40, 4'h5), write_req(32'h50, 32'h5555_5555, 4'hf, 4'h6));
    add_row(4, read_req(32'h0c, 4'h7), read_req(32'h1c, 4'h8));
    add_row(4, no_req(), read_req(32'h50, 4'h9));
    // Back-to-back reads, then write before read across ports
    for (int i = 0; i < 6; i++) begin
      add_row(5, read_req(32'(i * 4), 4'(i)), no_req());
    end
    add_row(5, no_req(), write_req(32'h14, 32'hd0d0_d0d0, 4'hf, 4'h6));
    add_row(5, read_req(32'h14, 4'h7), no_req());
    add_row(5, read_req(32'h18, 4'h8), write_req(32'h18, 32'he1e1_e1e1, 4'hf, 4'h9));
    add_row(5, read_req(32'h18, 4'ha), no_req());
    for (int i = 0; i < 24; i++) begin
      add_row(6, random_req(), random_req());
    end
  endtask

  // Starts and ends on a falling edge, repeats a port only until granted
  task automatic apply_row(input int r);
    logic core_pend, dma_pend;
    core_pend = core_tab[r].req;
    dma_pend  = dma_tab[r].req;
    test_num  = test_tab[r];
    do begin
      core_drv     = core_tab[r];
      core_drv.req = core_pend;
      dma_drv      = dma_tab[r];
      dma_drv.req  = dma_pend;
      @(posedge clk_i);
      if (core_gnt) core_pend = 1'b0;  // Accepted, not issued twice
      if (dma_gnt) dma_pend = 1'b0;
      @(negedge clk_i);
    end while (core_pend || dma_pend);
  endtask

  task automatic drain();
    core_drv = no_req();
    dma_drv  = no_req();
    while (!chk_idle) @(negedge clk_i);
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles with requests or responses pending",
               cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    core_drv = no_req();
    dma_drv  = no_req();
    rst_ni   = 1'b0;
    test_num = 0;
    all_sent = 1'b0;
    void'($urandom(32'h9ca4));
    build_table();
    cycle_limit = 4 * num_rows + 100;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int r = 0; r < num_rows; r++) begin
      if (r > 0 && test_tab[r] != test_tab[r-1]) drain();  // Close each test cleanly
      apply_row(r);
    end
    drain();
    all_sent = 1'b1;
    while (!chk_done) @(negedge clk_i);
    if (chk_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_tcdm_subsystem

//--- flist.f
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_port_decoder.sv
hw/tcdm_bank_arbiter.sv
hw/tcdm_banks_wrap.sv
hw/tcdm_subsystem.sv
testbench/tcdm_checker.sv
testbench/tb_tcdm_subsystem.sv

//--- Bender.yml
package:
  name: tcdm_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/tcdm_pkg.sv
      - hw/tcdm_port_decoder.sv
      - hw/tcdm_bank_arbiter.sv
      - hw/tcdm_banks_wrap.sv
      - hw/tcdm_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tcdm_checker.sv
      - testbench/tb_tcdm_subsystem.sv
